// ==== hw/fir_types_pkg.sv ====
////////////////////
// Data path widths and sample types shared by the FIR core, the round/clip
// stage and the testbench model. Import where a sample or coefficient is used.
////////////////////

package fir_types_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One I or Q lane of a stream word
  localparam int SAMPLE_W = 16;

  // One filter tap as written over the settings bus
  localparam int COEFF_W = 16;

  // Full precision of one sample times one tap
  localparam int PROD_W = SAMPLE_W + COEFF_W;

  ////////////////////
  // Types
  ////////////////////

  // Two's complement lane value, I in word bits 31:16, Q in 15:0
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Real tap value, applied to both lanes alike
  typedef logic signed [COEFF_W-1:0] coeff_t;

  // Limits of a lane after rounding, used for saturation
  localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
  localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

  // Lane positions inside a 32-bit stream word
  localparam int LANE_I_LSB = SAMPLE_W;
  localparam int LANE_Q_LSB = 0;

endpackage : fir_types_pkg

// ==== hw/fir_regs_pkg.sv ====
////////////////////
// Settings bus register map and readback encodings for the FIR block.
// Shared by the settings decoder and the testbench.
////////////////////

package fir_regs_pkg;

  // Settings register addresses, one write per strobe
  typedef enum logic [7:0] {
    SR_COEFF_LOAD = 8'd129,  // push one tap into the shadow set
    SR_COEFF_LAST = 8'd130,  // push one tap and commit the shadow set
    SR_READBACK   = 8'd255   // choose the word shown on the readback port
  } set_addr_e;

  // Readback select, taken from the low bits of an SR_READBACK write
  typedef enum logic [2:0] {
    RB_NUM_TAPS     = 3'd0,
    RB_RELOAD_COUNT = 3'd1
  } rb_sel_e;

  // Returned for any select that has no register behind it
  localparam logic [63:0] RB_BAD_VALUE = 64'h0BAD_C0DE_0BAD_C0DE;

  // Bits of the reload word counter
  localparam int RELOAD_CNT_W = 16;

endpackage : fir_regs_pkg

// ==== hw/fir_settings.sv ====
////////////////////
// Settings bus decoder. Collects coefficient reloads into a shadow set,
// commits them on the last word and drives the selected readback word.
////////////////////

module fir_settings #(
  parameter int NUM_TAPS = 8
) (
  input  logic                                 i_ce_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_set_stb,
  input  logic [7:0]                           i_set_addr,
  input  logic [31:0]                          i_set_data,
  output fir_types_pkg::coeff_t [NUM_TAPS-1:0] o_coeffs,
  output logic [63:0]                          o_rb_data
);

  import fir_types_pkg::*;
  import fir_regs_pkg::*;

  logic                       coeff_wr;
  logic                       coeff_commit;
  logic                       rb_wr;
  coeff_t [NUM_TAPS-1:0]      shadow;
  coeff_t [NUM_TAPS-1:0]      shadow_next;
  logic [RELOAD_CNT_W-1:0]    word_cnt;
  logic [RELOAD_CNT_W-1:0]    reload_cnt;
  rb_sel_e                    rb_sel;

  ////////////////////
  // Address decode
  ////////////////////

  assign coeff_commit = i_set_stb && (i_set_addr == SR_COEFF_LAST);
  assign coeff_wr     = coeff_commit || (i_set_stb && (i_set_addr == SR_COEFF_LOAD));
  assign rb_wr        = i_set_stb && (i_set_addr == SR_READBACK);

  // New word enters at the top, so the first of NUM_TAPS writes ends in tap 0
  assign shadow_next = {coeff_t'(i_set_data[COEFF_W-1:0]), shadow[NUM_TAPS-1:1]};

  ////////////////////
  // Coefficient sets
  ////////////////////

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      shadow   <= '0;
      o_coeffs <= '0;
    end else if (coeff_wr) begin
      shadow <= shadow_next;
      // Active set takes the word written in this same cycle
      if (coeff_commit) begin
        o_coeffs <= shadow_next;
      end
    end
  end

  // Words per sequence, latched on commit for readback
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      word_cnt   <= '0;
      reload_cnt <= '0;
    end else if (coeff_commit) begin
      word_cnt   <= '0;
      reload_cnt <= word_cnt + 1'b1;
    end else if (coeff_wr) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  ////////////////////
  // Readback
  ////////////////////

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rb_sel <= RB_NUM_TAPS;
    end else if (rb_wr) begin
      // Unlisted selects are kept so they read back the filler
      rb_sel <= rb_sel_e'(i_set_data[2:0]);
    end
  end

  always_comb begin
    case (rb_sel)
      RB_NUM_TAPS:     o_rb_data = 64'(NUM_TAPS);
      RB_RELOAD_COUNT: o_rb_data = 64'(reload_cnt);
      default:         o_rb_data = RB_BAD_VALUE;
    endcase
  end

endmodule : fir_settings

// ==== hw/fir_core.sv ====
////////////////////
// Complex FIR data path. Delay line, parallel multiplies and an adder per lane,
// two register stages held by one enable so back-pressure stalls everything.
////////////////////

module fir_core #(
  parameter int NUM_TAPS = 8,
  parameter int ACC_W    = 36
) (
  input  logic                                 i_ce_clk,
  input  logic                                 i_rst_n,
  input  fir_types_pkg::coeff_t [NUM_TAPS-1:0] i_coeffs,
  input  logic [31:0]                          i_data,
  input  logic                                 i_last,
  input  logic                                 i_valid,
  output logic                                 o_ready,
  output logic signed [ACC_W-1:0]              o_acc_i,
  output logic signed [ACC_W-1:0]              o_acc_q,
  output logic                                 o_last,
  output logic                                 o_valid,
  input  logic                                 i_ready
);

  import fir_types_pkg::*;

  logic                     advance;
  logic                     accept;
  sample_t                  dly_i  [NUM_TAPS-1];
  sample_t                  dly_q  [NUM_TAPS-1];
  sample_t                  win_i  [NUM_TAPS];
  sample_t                  win_q  [NUM_TAPS];
  logic signed [PROD_W-1:0] prod_i [NUM_TAPS];
  logic signed [PROD_W-1:0] prod_q [NUM_TAPS];
  logic                     s1_valid;
  logic                     s1_last;
  logic signed [ACC_W-1:0]  sum_i;
  logic signed [ACC_W-1:0]  sum_q;

  // Output register empty or being taken this cycle
  assign advance = !o_valid || i_ready;
  assign o_ready = advance;
  assign accept  = i_valid && advance;

  ////////////////////
  // Delay line
  ////////////////////

  // Tap 0 is the incoming sample, tap k the one from k samples earlier
  always_comb begin
    win_i[0] = sample_t'(i_data[LANE_I_LSB +: SAMPLE_W]);
    win_q[0] = sample_t'(i_data[LANE_Q_LSB +: SAMPLE_W]);
    for (int k = 1; k < NUM_TAPS; k++) begin
      win_i[k] = dly_i[k-1];
      win_q[k] = dly_q[k-1];
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        dly_i[k] <= '0;
        dly_q[k] <= '0;
      end
    end else if (accept) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        dly_i[k] <= win_i[k];
        dly_q[k] <= win_q[k];
      end
    end
  end

  ////////////////////
  // Stage one, products
  ////////////////////

  // Products use the taps active at acceptance
  always_ff @(posedge i_ce_clk) begin
    if (advance) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        prod_i[k] <= win_i[k] * i_coeffs[k];
        prod_q[k] <= win_q[k] * i_coeffs[k];
      end
      s1_last <= i_last;
    end
  end

  ////////////////////
  // Stage two, sums
  ////////////////////

  always_comb begin
    sum_i = '0;
    sum_q = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      sum_i = sum_i + prod_i[k];
      sum_q = sum_q + prod_q[k];
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (advance) begin
      o_acc_i <= sum_i;
      o_acc_q <= sum_q;
      o_last  <= s1_last;
    end
  end

  // Valid bits mark which stages hold a sample
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end else if (advance) begin
      s1_valid <= accept;
      o_valid  <= s1_valid;
    end
  end

endmodule : fir_core

// ==== hw/round_clip_complex.sv ====
////////////////////
// Rounds both accumulator lanes to nearest, half up, then saturates
// to sample range and packs I/Q into one registered stream word.
////////////////////

module round_clip_complex #(
  parameter int WIDTH_IN  = 36,
  parameter int DROP_BITS = 15
) (
  input  logic                       i_ce_clk,
  input  logic                       i_rst_n,
  input  logic signed [WIDTH_IN-1:0] i_acc_i,
  input  logic signed [WIDTH_IN-1:0] i_acc_q,
  input  logic                       i_last,
  input  logic                       i_valid,
  output logic                       o_ready,
  output logic [31:0]                o_data,
  output logic                       o_last,
  output logic                       o_valid,
  input  logic                       i_ready
);

  import fir_types_pkg::*;

  // One extra bit so the rounding add cannot wrap
  localparam logic signed [WIDTH_IN:0] HALF_LSB = (WIDTH_IN + 1)'(1) << (DROP_BITS - 1);
  localparam logic signed [WIDTH_IN:0] MAX_OUT  = SAMPLE_MAX;
  localparam logic signed [WIDTH_IN:0] MIN_OUT  = SAMPLE_MIN;

  logic advance;

  function automatic sample_t rnd_clip(input logic signed [WIDTH_IN-1:0] acc);
    logic signed [WIDTH_IN:0] biased;
    logic signed [WIDTH_IN:0] shifted;
    biased  = {acc[WIDTH_IN-1], acc} + HALF_LSB;
    shifted = biased >>> DROP_BITS;
    if (shifted > MAX_OUT) begin
      return sample_t'(SAMPLE_MAX);
    end else if (shifted < MIN_OUT) begin
      return sample_t'(SAMPLE_MIN);
    end
    return sample_t'(shifted[SAMPLE_W-1:0]);
  endfunction

  assign advance = !o_valid || i_ready;
  assign o_ready = advance;

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (advance) begin
      o_data <= {rnd_clip(i_acc_i), rnd_clip(i_acc_q)};
      o_last <= i_last;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (advance) begin
      o_valid <= i_valid;
    end
  end

endmodule : round_clip_complex

// ==== hw/fir_block.sv ====
////////////////////
// FIR stream block top. Settings decoder, complex FIR core and round/clip
// output stage on the single ce_clk domain.
////////////////////

module fir_block #(
  parameter int NUM_TAPS  = 8,
  parameter int DROP_BITS = 15
) (
  input  logic        i_ce_clk,
  input  logic        i_rst_n,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  output logic [63:0] o_rb_data,
  input  logic [31:0] i_in_tdata,
  input  logic        i_in_tlast,
  input  logic        i_in_tvalid,
  output logic        o_in_tready,
  output logic [31:0] o_out_tdata,
  output logic        o_out_tlast,
  output logic        o_out_tvalid,
  input  logic        i_out_tready
);

  import fir_types_pkg::*;

  // Product width plus growth for summing NUM_TAPS products
  localparam int ACC_W = PROD_W + $clog2(NUM_TAPS + 1);

  coeff_t [NUM_TAPS-1:0]   coeffs;
  logic signed [ACC_W-1:0] acc_i;
  logic signed [ACC_W-1:0] acc_q;
  logic                    acc_last;
  logic                    acc_valid;
  logic                    acc_ready;

  fir_settings #(
    .NUM_TAPS (NUM_TAPS)
  ) fir_settings_inst (
    .i_ce_clk   (i_ce_clk),
    .i_rst_n    (i_rst_n),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_coeffs   (coeffs),
    .o_rb_data  (o_rb_data)
  );

  fir_core #(
    .NUM_TAPS (NUM_TAPS),
    .ACC_W    (ACC_W)
  ) fir_core_inst (
    .i_ce_clk (i_ce_clk),
    .i_rst_n  (i_rst_n),
    .i_coeffs (coeffs),
    .i_data   (i_in_tdata),
    .i_last   (i_in_tlast),
    .i_valid  (i_in_tvalid),
    .o_ready  (o_in_tready),
    .o_acc_i  (acc_i),
    .o_acc_q  (acc_q),
    .o_last   (acc_last),
    .o_valid  (acc_valid),
    .i_ready  (acc_ready)
  );

  round_clip_complex #(
    .WIDTH_IN  (ACC_W),
    .DROP_BITS (DROP_BITS)
  ) round_clip_inst (
    .i_ce_clk (i_ce_clk),
    .i_rst_n  (i_rst_n),
    .i_acc_i  (acc_i),
    .i_acc_q  (acc_q),
    .i_last   (acc_last),
    .i_valid  (acc_valid),
    .o_ready  (acc_ready),
    .o_data   (o_out_tdata),
    .o_last   (o_out_tlast),
    .o_valid  (o_out_tvalid),
    .i_ready  (i_out_tready)
  );

endmodule : fir_block

// ==== tests/fir_block_chk.sv ====
////////////////////
// Stream handshake and reset checks, bound into the FIR block top
////////////////////

module fir_block_chk (
  input logic        i_ce_clk,
  input logic        i_rst_n,
  input logic [31:0] i_out_tdata,
  input logic        i_out_tlast,
  input logic        i_out_tvalid,
  input logic        i_out_tready,
  input logic        i_in_tready
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far
  int fail_cnt = 0;

  // Nothing leaves the block in the first cycle out of reset
  assert property (@(posedge i_ce_clk) $rose(i_rst_n) |-> !i_out_tvalid)
    else begin
      fail_cnt++;
      $error("o_out_tvalid high in first cycle after reset");
    end

  // Stalled output word holds until taken
  assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    i_out_tvalid && !i_out_tready |=>
      i_out_tvalid && $stable(i_out_tdata) && $stable(i_out_tlast))
    else begin
      fail_cnt++;
      $error("output word changed while stalled");
    end

  // An empty output register never blocks the input
  assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    !i_out_tvalid |-> i_in_tready)
    else begin
      fail_cnt++;
      $error("o_in_tready low with o_out_tvalid low");
    end

endmodule : fir_block_chk

bind fir_block fir_block_chk fir_block_chk_inst (
  .i_ce_clk     (i_ce_clk),
  .i_rst_n      (i_rst_n),
  .i_out_tdata  (o_out_tdata),
  .i_out_tlast  (o_out_tlast),
  .i_out_tvalid (o_out_tvalid),
  .i_out_tready (i_out_tready),
  .i_in_tready  (o_in_tready)
);

// ==== tests/fir_block_tb.sv ====
////////////////////
// Testbench for the FIR stream block. Drives settings and stream ports,
// models the filter and compares every output word in order.
////////////////////

module fir_block_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fir_types_pkg::*;
  import fir_regs_pkg::*;

  localparam int NUM_TAPS    = 8;
  localparam int DROP_BITS   = 15;
  // Impulse, random, round/clip and reload tests
  localparam int N_SAMPLES   = 12 + 200 + 22 + 60;
  localparam int WATCHDOG_NS = N_SAMPLES * 8 * 20 + 2000;

  logic        i_ce_clk = 1'b0;
  logic        i_rst_n;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [63:0] o_rb_data;
  logic [31:0] i_in_tdata;
  logic        i_in_tlast;
  logic        i_in_tvalid;
  logic        o_in_tready;
  logic [31:0] o_out_tdata;
  logic        o_out_tlast;
  logic        o_out_tvalid;
  logic        i_out_tready;

  logic [32:0] exp_q [$];
  coeff_t      m_shadow [NUM_TAPS];
  coeff_t      m_coeff  [NUM_TAPS];
  sample_t     m_hist_i [NUM_TAPS];
  sample_t     m_hist_q [NUM_TAPS];
  logic        bp_en;
  int          err_count;
  int          test_errs;
  int          tests_pass;
  int          tests_fail;
  int          assert_fails;

  always #10 i_ce_clk = ~i_ce_clk;

  fir_block #(
    .NUM_TAPS  (NUM_TAPS),
    .DROP_BITS (DROP_BITS)
  ) fir_block_inst (
    .i_ce_clk     (i_ce_clk),
    .i_rst_n      (i_rst_n),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .o_rb_data    (o_rb_data),
    .i_in_tdata   (i_in_tdata),
    .i_in_tlast   (i_in_tlast),
    .i_in_tvalid  (i_in_tvalid),
    .o_in_tready  (o_in_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tlast  (o_out_tlast),
    .o_out_tvalid (o_out_tvalid),
    .i_out_tready (i_out_tready)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Nearest integer with ties toward plus infinity, then clamp to 16 bits
  function automatic sample_t scale_to_sample(input longint acc);
    longint r;
    r = (acc + (longint'(1) << (DROP_BITS - 1))) >>> DROP_BITS;
    if (r > 32767) begin
      return 16'sh7fff;
    end else if (r < -32768) begin
      return 16'sh8000;
    end
    return sample_t'(r);
  endfunction

  function automatic logic [31:0] fir_model(input logic [31:0] word);
    longint acc_i;
    longint acc_q;
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      m_hist_i[k] = m_hist_i[k-1];
      m_hist_q[k] = m_hist_q[k-1];
    end
    m_hist_i[0] = word[31:16];
    m_hist_q[0] = word[15:0];
    acc_i = 0;
    acc_q = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc_i += longint'(m_hist_i[k]) * longint'(m_coeff[k]);
      acc_q += longint'(m_hist_q[k]) * longint'(m_coeff[k]);
    end
    return {scale_to_sample(acc_i), scale_to_sample(acc_q)};
  endfunction

  // Newest word enters at the top tap and older words move down
  task automatic model_set_write(input logic [7:0] addr, input logic [31:0] data);
    if (addr == SR_COEFF_LOAD || addr == SR_COEFF_LAST) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        m_shadow[k] = m_shadow[k+1];
      end
      m_shadow[NUM_TAPS-1] = data[15:0];
      if (addr == SR_COEFF_LAST) begin
        m_coeff = m_shadow;
      end
    end
  endtask

  // Sample first, so a commit in the same cycle misses it
  always @(negedge i_ce_clk) begin
    if (i_rst_n) begin
      if (i_in_tvalid && o_in_tready) begin
        exp_q.push_back({i_in_tlast, fir_model(i_in_tdata)});
      end
      if (i_set_stb) begin
        model_set_write(i_set_addr, i_set_data);
      end
    end
  end

  ////////////////////
  // Compare
  ////////////////////

  task automatic check_sample(input string name, input sample_t want, input sample_t got);
    if (got !== want) begin
      err_count++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, want, got);
    end
  endtask

  task automatic check_last(input logic want, input logic got);
    if (got !== want) begin
      err_count++;
      $display("** Error: o_out_tlast expected 0x%h, got 0x%h", want, got);
    end
  endtask

  task automatic check_rb(input logic [63:0] want, input logic [63:0] got);
    if (got !== want) begin
      err_count++;
      $display("** Error: o_rb_data expected 0x%h, got 0x%h", want, got);
    end
  endtask

  always @(negedge i_ce_clk) begin : compare_out
    logic [32:0] want;
    if (i_rst_n && o_out_tvalid && i_out_tready) begin
      if (exp_q.size() == 0) begin
        err_count++;
        $display("Output word %h came out with no sample waiting for it", o_out_tdata);
      end else begin
        want = exp_q.pop_front();
        check_sample("o_out_tdata[31:16]", want[31:16], o_out_tdata[31:16]);
        check_sample("o_out_tdata[15:0]", want[15:0], o_out_tdata[15:0]);
        check_last(want[32], o_out_tlast);
      end
    end
  end

  ////////////////////
  // Drivers
  ////////////////////

  task automatic tick();
    @(posedge i_ce_clk);
    #2;
  endtask

  task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    tick();
    i_set_stb = 1'b0;
  endtask

  // Words go out tap 0 first, the final one commits
  task automatic load_words(input coeff_t [NUM_TAPS-1:0] c, input int count);
    for (int k = 0; k < count; k++) begin
      set_write(k == count - 1 ? SR_COEFF_LAST : SR_COEFF_LOAD, {16'h0, c[k]});
    end
  endtask

  task automatic readback(input logic [2:0] sel, input logic [63:0] want);
    set_write(SR_READBACK, {29'd0, sel});
    @(negedge i_ce_clk);
    check_rb(want, o_rb_data);
    tick();
  endtask

  task automatic send_sample(input sample_t si, input sample_t sq, input logic last);
    logic taken;
    i_in_tdata  = {si, sq};
    i_in_tlast  = last;
    i_in_tvalid = 1'b1;
    do begin
      @(negedge i_ce_clk);
      taken = o_in_tready;
      tick();
      if (bp_en) begin
        i_out_tready = ($urandom_range(0, 99) >= 30);
      end
    end while (!taken);
    i_in_tvalid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    bp_en        = 1'b0;
    i_out_tready = 1'b1;
    waited       = 0;
    while (exp_q.size() != 0 && waited < 64) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) begin
      err_count++;
      $display("Output stream stuck, %0d expected words never came out", exp_q.size());
    end
  endtask

  task automatic end_test(input string name);
    if (err_count == test_errs) begin
      tests_pass++;
      $display("test %-20s passed", name);
    end else begin
      tests_fail++;
      $display("test %-20s failed with %0d errors", name, err_count - test_errs);
    end
    test_errs = err_count;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin : run_tests
    logic [31:0] rnd;
    void'($urandom(64));
    {i_set_stb, i_set_addr, i_set_data} = '0;
    {i_in_tdata, i_in_tlast, i_in_tvalid} = '0;
    i_out_tready = 1'b1;
    i_rst_n      = 1'b0;
    bp_en        = 1'b0;
    {err_count, test_errs, tests_pass, tests_fail} = '0;
    foreach (m_coeff[k]) begin
      m_shadow[k] = '0;
      m_coeff[k]  = '0;
      m_hist_i[k] = '0;
      m_hist_q[k] = '0;
    end
    repeat (4) @(posedge i_ce_clk);
    #2;
    i_rst_n = 1'b1;

    @(negedge i_ce_clk);
    if (o_out_tvalid !== 1'b0 || o_in_tready !== 1'b1) begin
      err_count++;
      $display("After reset o_out_tvalid should be low and o_in_tready high");
    end
    tick();
    readback(RB_NUM_TAPS, 64'd8);
    readback(3'd5, RB_BAD_VALUE);
    readback(RB_RELOAD_COUNT, 64'd0);
    end_test("reset and readback");

    // Tap 7 down to tap 0
    load_words({16'sd300, -16'sd1, 16'sd7, 16'sd32767,
                -16'sd32768, 16'sd8000, -16'sd4321, 16'sd1234}, NUM_TAPS);
    send_sample(16384, -16384, 1'b0);
    for (int n = 0; n < 11; n++) begin
      send_sample(0, 0, n == 10);
    end
    drain();
    readback(RB_RELOAD_COUNT, 64'd8);
    end_test("impulse response");

    bp_en = 1'b1;
    for (int n = 0; n < 200; n++) begin
      rnd = $urandom;
      send_sample(rnd[31:16], rnd[15:0], $urandom_range(0, 7) == 0);
    end
    drain();
    end_test("random stream");

    load_words({NUM_TAPS{16'sd32767}}, NUM_TAPS);
    for (int n = 0; n < 8; n++) begin
      send_sample(32767, -32768, 1'b0);
    end
    for (int n = 0; n < 8; n++) begin
      send_sample(-32768, 32767, n == 7);
    end
    // Gain of two in tap 0, odd multiples of 8192 sit on the half LSB
    load_words({{(NUM_TAPS - 1) * 16{1'b0}}, 16'sd2}, NUM_TAPS);
    send_sample(8192, -8192, 1'b0);
    send_sample(24576, -24576, 1'b0);
    send_sample(-24576, 24576, 1'b0);
    send_sample(8193, -8193, 1'b0);
    send_sample(16384, -16384, 1'b0);
    send_sample(32767, -32768, 1'b1);
    drain();
    end_test("round and clip");

    fork
      for (int n = 0; n < 40; n++) begin
        rnd = $urandom;
        send_sample(rnd[31:16], rnd[15:0], n == 39);
      end
      begin
        repeat (10) tick();
        load_words({16'sd100, -16'sd200, 16'sd400, -16'sd800,
                    16'sd1600, -16'sd3200, 16'sd6400, 16'sd12800}, NUM_TAPS);
        repeat (4) tick();
        load_words({{(NUM_TAPS - 5) * 16{1'b0}},
                    16'sd3000, 16'sd1500, 16'sd0, -16'sd1500, -16'sd3000}, 5);
      end
    join
    for (int n = 0; n < 20; n++) begin
      rnd = $urandom;
      send_sample(rnd[31:16], rnd[15:0], n == 19);
    end
    drain();
    readback(RB_RELOAD_COUNT, 64'd5);
    end_test("reload while streaming");

    // Handshake assertions bound into the DUT
    assert_fails = fir_block_inst.fir_block_chk_inst.fail_cnt;
    if (assert_fails != 0) begin
      $display("Bound handshake assertions failed %0d times", assert_fails);
    end

    $display("tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && err_count == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, the run did not finish in time", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule : fir_block_tb

// ==== tb.f ====
hw/fir_types_pkg.sv
hw/fir_regs_pkg.sv
hw/fir_settings.sv
hw/fir_core.sv
hw/round_clip_complex.sv
hw/fir_block.sv
tests/fir_block_chk.sv
tests/fir_block_tb.sv
